//--- hw/scope_pkg.sv
// shared definitions for the logic-analyzer capture block
// sample and memory sizes, APB widths
// register map with bit positions and reset defaults

package scope_pkg;

    // sample memory geometry
    localparam int sample_bits   = 8;
    localparam int mem_depth     = 256;
    localparam int mem_addr_bits = 8;
    // holds 1 to mem_depth inclusive
    localparam int count_bits    = 9;

    // APB bus widths
    localparam int apb_addr_bits = 12;
    localparam int apb_data_bits = 32;

    // register addresses
    localparam logic [apb_addr_bits-1:0] reg_ctrl   = 12'h000;
    localparam logic [apb_addr_bits-1:0] reg_status = 12'h004;
    localparam logic [apb_addr_bits-1:0] reg_config = 12'h008;
    localparam logic [apb_addr_bits-1:0] reg_count  = 12'h00C;
    // sample i sits at mem_base + 4*i
    localparam logic [apb_addr_bits-1:0] mem_base   = 12'h400;

    // bit positions inside the registers
    localparam int ctrl_soft_rst_bit  = 0;
    localparam int ctrl_start_bit     = 1;
    localparam int status_done_bit    = 0;
    localparam int status_busy_bit    = 1;
    localparam int config_trig_en_bit = 0;

    // reset value of the count register
    localparam logic [count_bits-1:0] count_default = count_bits'(mem_depth);

endpackage

//--- hw/scope_sample_mem.sv
// sample memory of the capture block
// simple dual port array, capture write port and
// synchronous bus read port, block RAM style without reset

`timescale 1ns/1ps

module scope_sample_mem import scope_pkg::*; (
    input  logic                      BUS_CLK,
    input  logic                      wr_en,
    input  logic [mem_addr_bits-1:0]  wr_addr,
    input  logic [sample_bits-1:0]    wr_data,
    input  logic [mem_addr_bits-1:0]  rd_addr,
    output logic [sample_bits-1:0]    rd_data
);

    logic [sample_bits-1:0] mem [mem_depth];

    // capture side
    always_ff @(posedge BUS_CLK) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // bus side, one cycle read latency
    always_ff @(posedge BUS_CLK) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hw/scope_capture.sv
// capture control
// arming on software start or enabled trigger
// sample index, memory write strobe, busy and done state

`timescale 1ns/1ps

module scope_capture import scope_pkg::*; (
    input  logic                      BUS_CLK,
    input  logic                      RST,
    input  logic                      soft_rst,
    input  logic                      start,
    input  logic                      trig_en,
    input  logic                      trigger,
    input  logic [count_bits-1:0]     count,
    input  logic [sample_bits-1:0]    seq_in,
    output logic                      wr_en,
    output logic [mem_addr_bits-1:0]  wr_addr,
    output logic [sample_bits-1:0]    wr_data,
    output logic                      busy,
    output logic                      done
);

    logic [mem_addr_bits-1:0]  idx;
    logic [mem_addr_bits-1:0]  last_idx;
    logic [mem_addr_bits-1:0]  count_m1;
    logic                      arm;

    // count is 1..mem_depth, so count-1 always fits the index
    assign count_m1 = mem_addr_bits'(count - 1'b1);

    // start also restarts a running capture,
    // the trigger only arms from idle
    assign arm = start || (trig_en && trigger && !busy);

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_rst) begin
            busy <= 1'b0;
            done <= 1'b1;
            idx  <= '0;
        end else if (arm) begin
            // restart takes priority over completion
            busy <= 1'b1;
            done <= 1'b0;
            idx  <= '0;
        end else if (busy) begin
            if (idx == last_idx) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // length is frozen at arm time, later count writes
    // only affect the next capture
    always_ff @(posedge BUS_CLK) begin
        if (arm) begin
            last_idx <= count_m1;
        end
    end

    // one sample per running cycle, taken at the writing edge
    assign wr_en   = busy;
    assign wr_addr = idx;
    assign wr_data = seq_in;

endmodule

//--- hw/scope_apb_regs.sv
// APB slave of the capture block
// address decode for registers and the sample memory window
// config and count registers, start and soft reset pulses
// read multiplexer and slave error response

`timescale 1ns/1ps

module scope_apb_regs import scope_pkg::*; (
    input  logic                      BUS_CLK,
    input  logic                      RST,
    input  logic [apb_addr_bits-1:0]  paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [apb_data_bits-1:0]  pwdata,
    output logic [apb_data_bits-1:0]  prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      busy,
    input  logic                      done,
    input  logic [sample_bits-1:0]    rd_data,
    output logic [mem_addr_bits-1:0]  rd_addr,
    output logic                      soft_rst,
    output logic                      start,
    output logic                      trig_en,
    output logic [count_bits-1:0]     count
);

    logic                      access;
    logic                      is_ctrl;
    logic                      is_status;
    logic                      is_config;
    logic                      is_count;
    logic                      is_mem;
    logic [apb_addr_bits-1:0]  mem_off;
    logic                      bad_count;
    logic                      err;
    logic                      wr_ok;

    // second phase of a transfer
    assign access = psel && penable;

    assign is_ctrl   = (paddr == reg_ctrl);
    assign is_status = (paddr == reg_status);
    assign is_config = (paddr == reg_config);
    assign is_count  = (paddr == reg_count);

    // memory window, word aligned and below mem_depth slots
    assign mem_off = paddr - mem_base;
    assign is_mem  = (paddr >= mem_base) && (mem_off[1:0] == 2'b00) &&
                     (mem_off[apb_addr_bits-1:2] < mem_depth);

    // the address is stable from the setup cycle on, so the
    // synchronous memory read lands in the access cycle
    assign rd_addr = mem_off[mem_addr_bits+1:2];

    assign bad_count = (pwdata == '0) || (pwdata > mem_depth);

    always_comb begin
        err = 1'b0;
        if (!(is_ctrl || is_status || is_config || is_count || is_mem)) begin
            err = 1'b1;
        end else if (pwrite && (is_status || is_mem)) begin
            // status is read only, sample memory is filled by capture only
            err = 1'b1;
        end else if (pwrite && is_count && bad_count) begin
            err = 1'b1;
        end
    end

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access && err;

    // a refused write changes nothing
    assign wr_ok = access && pwrite && !err;

    // one cycle pulses, acted on at the edge that ends the access
    assign soft_rst = wr_ok && is_ctrl && pwdata[ctrl_soft_rst_bit];
    assign start    = wr_ok && is_ctrl && pwdata[ctrl_start_bit];

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_rst) begin
            trig_en <= 1'b0;
            count   <= count_default;
        end else begin
            if (wr_ok && is_config) begin
                trig_en <= pwdata[config_trig_en_bit];
            end
            if (wr_ok && is_count) begin
                count <= pwdata[count_bits-1:0];
            end
        end
    end

    // read mux, ctrl and unmapped addresses read as zero
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (is_status) begin
                prdata[status_done_bit] = done;
                prdata[status_busy_bit] = busy;
            end else if (is_config) begin
                prdata[config_trig_en_bit] = trig_en;
            end else if (is_count) begin
                prdata[count_bits-1:0] = count;
            end else if (is_mem) begin
                prdata[sample_bits-1:0] = rd_data;
            end
        end
    end

endmodule

//--- hw/scope_top.sv
// top level of the logic-analyzer capture block
// APB register slave, capture control and sample memory

`timescale 1ns/1ps

module scope_top import scope_pkg::*; (
    input  logic                      BUS_CLK,
    input  logic                      RST,
    input  logic [apb_addr_bits-1:0]  paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [apb_data_bits-1:0]  pwdata,
    output logic [apb_data_bits-1:0]  prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic [sample_bits-1:0]    seq_in,
    input  logic                      trigger
);

    logic                      soft_rst;
    logic                      start;
    logic                      trig_en;
    logic [count_bits-1:0]     count;
    logic                      busy;
    logic                      done;
    logic                      wr_en;
    logic [mem_addr_bits-1:0]  wr_addr;
    logic [sample_bits-1:0]    wr_data;
    logic [mem_addr_bits-1:0]  rd_addr;
    logic [sample_bits-1:0]    rd_data;

    scope_apb_regs regs0 (
        .BUS_CLK  (BUS_CLK),
        .RST      (RST),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .busy     (busy),
        .done     (done),
        .rd_data  (rd_data),
        .rd_addr  (rd_addr),
        .soft_rst (soft_rst),
        .start    (start),
        .trig_en  (trig_en),
        .count    (count)
    );

    scope_capture capture0 (
        .BUS_CLK  (BUS_CLK),
        .RST      (RST),
        .soft_rst (soft_rst),
        .start    (start),
        .trig_en  (trig_en),
        .trigger  (trigger),
        .count    (count),
        .seq_in   (seq_in),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .busy     (busy),
        .done     (done)
    );

    scope_sample_mem mem0 (
        .BUS_CLK  (BUS_CLK),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

//--- testbench/tb_scope_tasks.svh
// APB transfer task, trigger pulse
// reference sample function and memory shadow update
// value check with error counters, register read and write checks
`ifndef TB_SCOPE_TASKS_SVH
`define TB_SCOPE_TASKS_SVH

int   errors = 0;
int   checks = 0;
// rising edge that ended the last APB transfer or trigger pulse
int   last_edge;
logic last_pready;

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
endtask

// setup cycle, access cycle, outputs sampled on the falling edge in between
task automatic apb_transfer(input logic wr, input logic [apb_addr_bits-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge BUS_CLK);
    paddr   <= addr;
    pwdata  <= wdata;
    pwrite  <= wr;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge BUS_CLK);
    penable <= 1'b1;
    @(negedge BUS_CLK);
    rdata       = prdata;
    err         = pslverr;
    last_pready = pready;
    last_edge   = cyc + 1;
    @(posedge BUS_CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
endtask

task automatic pulse_trigger();
    @(posedge BUS_CLK);
    trigger <= 1'b1;
    @(negedge BUS_CLK);
    // armed at the edge that samples the pulse
    last_edge = cyc + 1;
    @(posedge BUS_CLK);
    trigger <= 1'b0;
endtask

// sample i of a capture armed at edge e is seq_in at edge e+1+i,
// slots at or above the count keep their old value
function automatic logic [sample_bits-1:0] expected_sample(input int e, input int i,
        input int cnt, input logic [sample_bits-1:0] old);
    if (i < cnt) begin
        return seq_log[(e + 1 + i) % log_size];
    end
    return old;
endfunction

task automatic record_capture(input int e, input int cnt);
    for (int i = 0; i < mem_depth; i++) begin
        shadow[i] = expected_sample(e, i, cnt, shadow[i]);
        if (i < cnt) begin
            filled[i] = 1'b1;
        end
    end
endtask

task automatic read_expect(input string name, input logic [apb_addr_bits-1:0] addr,
                           input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] data;
    logic        err;
    apb_transfer(1'b0, addr, 32'h0, data, err);
    check_value({name, " pslverr"}, 32'(exp_err), 32'(err));
    check_value({name, " pready"}, 32'h1, 32'(last_pready));
    if (!exp_err) begin
        check_value(name, exp_data, data);
    end
endtask

task automatic write_expect(input string name, input logic [apb_addr_bits-1:0] addr,
                            input logic [31:0] data, input logic exp_err);
    logic [31:0] unused;
    logic        err;
    apb_transfer(1'b1, addr, data, unused, err);
    check_value({name, " pslverr"}, 32'(exp_err), 32'(err));
endtask

// poll status until done with busy low
task automatic wait_done(output logic saw_busy);
    logic [31:0] st;
    logic        err;
    saw_busy = 1'b0;
    do begin
        apb_transfer(1'b0, reg_status, 32'h0, st, err);
        if (st[status_busy_bit]) begin
            saw_busy = 1'b1;
        end
    end while (!(st[status_done_bit] && !st[status_busy_bit]));
endtask

// hand the readback over to the compare process and wait for it
task automatic verify_memory(input string name);
    verify_name = name;
    verify_busy = 1'b1;
    wait (!verify_busy);
endtask

`endif

//--- testbench/tb_scope.sv
// testbench of the logic-analyzer capture block
// clock, reset, scrambled input pattern, DUT instance
// test sequence, memory compare process, watchdog and summary

`timescale 1ns/1ps

module tb_scope import scope_pkg::*; ();

    localparam int clk_period = 100;
    localparam int n_sw_caps  = 6;
    // a capture with full readback costs about four memory passes
    localparam int num_tests  = 4 * (n_sw_caps + 6);
    localparam int wd_cycles  = num_tests * (mem_depth + 50);
    localparam int log_size   = 32768;

    logic                      BUS_CLK;
    logic                      RST;
    logic [apb_addr_bits-1:0]  paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_data_bits-1:0]  pwdata;
    logic [apb_data_bits-1:0]  prdata;
    logic                      pready;
    logic                      pslverr;
    logic [sample_bits-1:0]    seq_in;
    logic                      trigger;

    int                        cyc;
    // seq_log[n] is the value the DUT samples at edge n
    logic [sample_bits-1:0]    seq_log [log_size];
    // expected memory contents, and which slots hold a known value
    logic [sample_bits-1:0]    shadow [mem_depth];
    logic                      filled [mem_depth];
    logic                      verify_busy;
    string                     verify_name;

    `include "tb_scope_tasks.svh"

    scope_top dut0 (
        .BUS_CLK (BUS_CLK),
        .RST     (RST),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .seq_in  (seq_in),
        .trigger (trigger)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #(clk_period / 2) BUS_CLK = ~BUS_CLK;
    end

    // free running counter through a scrambler
    always @(posedge BUS_CLK) begin
        logic [31:0] v;
        v = 32'(cyc + 2) * 32'd37 + (32'(cyc + 2) >> 3);
        cyc <= cyc + 1;
        seq_in <= v[7:0] ^ v[12:5] ^ 8'h5a;
        seq_log[(cyc + 2) % log_size] = v[7:0] ^ v[12:5] ^ 8'h5a;
    end

    // reads back every known slot and compares with the shadow
    initial begin
        logic [31:0] rdata;
        logic        rerr;
        forever begin
            wait (verify_busy);
            for (int i = 0; i < mem_depth; i++) begin
                if (filled[i]) begin
                    apb_transfer(1'b0, mem_base + apb_addr_bits'(4 * i), 32'h0, rdata, rerr);
                    check_value($sformatf("%s slot %0d", verify_name, i),
                                32'(shadow[i]), rdata);
                end
            end
            verify_busy = 1'b0;
        end
    end

    initial begin
        repeat (wd_cycles) @(posedge BUS_CLK);
        $display("test sequence did not finish within %0d cycles", wd_cycles);
        $display("%0d checks, %0d errors", checks, errors);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int   seed;
        int   cnt;
        int   e_arm;
        logic saw_busy;
        seed = 87;
        cyc = 0;
        verify_busy = 1'b0;
        RST = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        seq_in = '0;
        trigger = 1'b0;
        for (int i = 0; i < mem_depth; i++) begin
            filled[i] = 1'b0;
            shadow[i] = '0;
        end
        repeat (10) @(posedge BUS_CLK);
        RST <= 1'b0;

        // reset defaults
        read_expect("reset status", reg_status, 32'h1, 1'b0);
        read_expect("reset config", reg_config, 32'h0, 1'b0);
        read_expect("reset count", reg_count, 32'd256, 1'b0);
        read_expect("reset ctrl", reg_ctrl, 32'h0, 1'b0);

        // software captures, both ends of the count range first
        for (int k = 0; k < n_sw_caps; k++) begin
            if (k == 0) begin
                cnt = 1;
            end else if (k == 1) begin
                cnt = mem_depth;
            end else begin
                cnt = ($random(seed) & 255) + 1;
            end
            write_expect("sw count", reg_count, cnt, 1'b0);
            write_expect("sw start", reg_ctrl, 32'h2, 1'b0);
            e_arm = last_edge;
            wait_done(saw_busy);
            if (cnt > 4) begin
                check_value("sw busy seen", 32'h1, 32'(saw_busy));
            end
            record_capture(e_arm, cnt);
            verify_memory($sformatf("sw capture count %0d", cnt));
        end

        // trigger ignored while disabled
        write_expect("trig config off", reg_config, 32'h0, 1'b0);
        pulse_trigger();
        repeat (4) @(posedge BUS_CLK);
        read_expect("trig disabled status", reg_status, 32'h1, 1'b0);
        verify_memory("trig disabled");

        // enabled trigger, second pulse lands while busy
        write_expect("trig count", reg_count, 32'd120, 1'b0);
        write_expect("trig config on", reg_config, 32'h1, 1'b0);
        read_expect("trig config", reg_config, 32'h1, 1'b0);
        pulse_trigger();
        e_arm = last_edge;
        repeat (20) @(posedge BUS_CLK);
        pulse_trigger();
        wait_done(saw_busy);
        check_value("trig busy seen", 32'h1, 32'(saw_busy));
        record_capture(e_arm, 120);
        verify_memory("trig capture");
        write_expect("trig config clear", reg_config, 32'h0, 1'b0);

        // soft reset in the middle of a capture
        write_expect("srst count", reg_count, 32'd200, 1'b0);
        write_expect("srst config", reg_config, 32'h1, 1'b0);
        write_expect("srst start", reg_ctrl, 32'h2, 1'b0);
        read_expect("srst running", reg_status, 32'h2, 1'b0);
        write_expect("srst pulse", reg_ctrl, 32'h1, 1'b0);
        read_expect("srst status", reg_status, 32'h1, 1'b0);
        read_expect("srst count", reg_count, 32'd256, 1'b0);
        read_expect("srst config", reg_config, 32'h0, 1'b0);
        // partly overwritten slots are no longer known
        for (int i = 0; i < mem_depth; i++) begin
            filled[i] = 1'b0;
        end

        // restart of a running capture
        write_expect("restart first", reg_ctrl, 32'h2, 1'b0);
        repeat (30) @(posedge BUS_CLK);
        read_expect("restart running", reg_status, 32'h2, 1'b0);
        write_expect("restart second", reg_ctrl, 32'h2, 1'b0);
        e_arm = last_edge;
        wait_done(saw_busy);
        record_capture(e_arm, mem_depth);
        verify_memory("restart capture");

        // error responses leave registers and memory alone
        write_expect("err count setup", reg_count, 32'd77, 1'b0);
        read_expect("err unmapped", 12'h010, 32'h0, 1'b1);
        read_expect("err misaligned", 12'h402, 32'h0, 1'b1);
        read_expect("err past window", 12'h800, 32'h0, 1'b1);
        write_expect("err status write", reg_status, 32'h3, 1'b1);
        // data differs from the stored sample of slot 5
        write_expect("err memory write", mem_base + 12'h014, 32'(~shadow[5]), 1'b1);
        write_expect("err count zero", reg_count, 32'd0, 1'b1);
        write_expect("err count 257", reg_count, 32'd257, 1'b1);
        read_expect("err count kept", reg_count, 32'd77, 1'b0);
        read_expect("err status kept", reg_status, 32'h1, 1'b0);
        verify_memory("err memory kept");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+testbench
hw/scope_pkg.sv
hw/scope_sample_mem.sv
hw/scope_capture.sv
hw/scope_apb_regs.sv
hw/scope_top.sv
testbench/tb_scope.sv

//--- Makefile
# Verilator build and run of the capture block testbench

VERILATOR  ?= verilator
TOP        := tb_scope
RTL_TOP    := scope_top
FILELIST   := src.f
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed
RTL_SRCS   := hw/scope_pkg.sv hw/scope_sample_mem.sv hw/scope_capture.sv \
              hw/scope_apb_regs.sv hw/scope_top.sv
TB_SRCS    := testbench/tb_scope.sv testbench/tb_scope_tasks.svh

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
